//--- ex_config.svh
`ifndef EX_CONFIG_SVH
`define EX_CONFIG_SVH

// Data path word width
`define EX_XLEN 32

// Register file address width, 32 registers
`define EX_RADDR_W 5

// ALU opcode width
// 16 operations fill the field exactly
`define EX_ALU_OP_W 4

`endif

//--- ex_pkg.sv
`include "ex_config.svh"

package ex_pkg;

  ////////////////////
  // ALU opcodes
  ////////////////////

  // Arithmetic, logic and shifts come first
  // Branch compares follow and only drive the compare flag
  typedef enum logic [`EX_ALU_OP_W-1:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU,
    ALU_EQ,
    ALU_NE,
    ALU_LT,
    ALU_GE,
    ALU_LTU,
    ALU_GEU
  } alu_op_e;

  ////////////////////
  // Multiplier modes
  ////////////////////

  // Bit 0 marks operand a as signed, bit 1 marks operand b
  // First letter of the name is for a, the second for b
  typedef enum logic [1:0] {
    MULT_UU = 2'b00,
    MULT_SU = 2'b01,
    MULT_US = 2'b10,
    MULT_SS = 2'b11
  } mult_sign_e;

endpackage

//--- ex_op_if.sv
`timescale 1ns/1ps
`include "ex_config.svh"

// Operation bundle handed from the stage top to the execute blocks
interface ex_op_if
  import ex_pkg::*;
();

  // ALU operation and its operands
  alu_op_e              operator;
  logic [`EX_XLEN-1:0]  operand_a;
  logic [`EX_XLEN-1:0]  operand_b;
  // Accumulator for MAC, jump target for branches
  logic [`EX_XLEN-1:0]  operand_c;

  // Multiplier controls
  logic                 vector_mode;
  logic                 mult_en;
  logic [1:0]           mult_sel_subword;
  mult_sign_e           mult_signed_mode;
  logic                 mult_mac_en;

  // Driving side at the stage top
  modport src (
    output operator, operand_a, operand_b, operand_c,
    output vector_mode, mult_en, mult_sel_subword, mult_signed_mode, mult_mac_en
  );

  modport alu (input operator, operand_a, operand_b);

  modport mult (
    input operand_a, operand_b, operand_c,
    input vector_mode, mult_en, mult_sel_subword, mult_signed_mode, mult_mac_en
  );

  modport ctrl (input mult_en, operand_c);

endinterface

//--- ex_alu.sv
`timescale 1ns/1ps
`include "ex_config.svh"

module ex_alu
  import ex_pkg::*;
(
  ex_op_if.alu                 op,
  output logic [`EX_XLEN-1:0]  result_o,
  output logic                 cmp_result_o
);

  localparam int SHAMT_W = $clog2(`EX_XLEN);

  // Shared adder, subtracts for everything except ADD
  logic                 is_sub;
  logic [`EX_XLEN-1:0]  adder_b;
  logic [`EX_XLEN:0]    adder_sum;

  // Compare terms taken from the adder
  logic                 is_equal;
  logic                 lt_signed;
  logic                 lt_unsigned;

  logic [SHAMT_W-1:0]   shamt;

  ////////////////////
  // Adder
  ////////////////////

  assign is_sub  = (op.operator != ALU_ADD);
  // Two's complement of b, the +1 enters as carry in
  assign adder_b = is_sub ? ~op.operand_b : op.operand_b;

  assign adder_sum = {1'b0, op.operand_a}
                   + {1'b0, adder_b}
                   + {{`EX_XLEN{1'b0}}, is_sub};

  // Zero difference means equal operands
  assign is_equal    = (adder_sum[`EX_XLEN-1:0] == '0);
  // No carry out of a - b means a borrowed, so a < b unsigned
  assign lt_unsigned = ~adder_sum[`EX_XLEN];
  // Signs differ: the negative one is smaller, else the difference sign decides
  assign lt_signed   = (op.operand_a[`EX_XLEN-1] ^ op.operand_b[`EX_XLEN-1])
                     ? op.operand_a[`EX_XLEN-1]
                     : adder_sum[`EX_XLEN-1];

  ////////////////////
  // Compare flag
  ////////////////////

  always_comb
  begin
    case (op.operator)
      ALU_EQ:            cmp_result_o = is_equal;
      ALU_NE:            cmp_result_o = ~is_equal;
      ALU_LT, ALU_SLT:   cmp_result_o = lt_signed;
      ALU_GE:            cmp_result_o = ~lt_signed;
      ALU_LTU, ALU_SLTU: cmp_result_o = lt_unsigned;
      ALU_GEU:           cmp_result_o = ~lt_unsigned;
      // Arithmetic and logic give no compare outcome
      default:           cmp_result_o = 1'b0;
    endcase
  end

  ////////////////////
  // Result word
  ////////////////////

  // Only the low bits of b count as shift amount
  assign shamt = op.operand_b[SHAMT_W-1:0];

  always_comb
  begin
    case (op.operator)
      ALU_ADD, ALU_SUB: result_o = adder_sum[`EX_XLEN-1:0];
      ALU_AND:          result_o = op.operand_a & op.operand_b;
      ALU_OR:           result_o = op.operand_a | op.operand_b;
      ALU_XOR:          result_o = op.operand_a ^ op.operand_b;
      ALU_SLL:          result_o = op.operand_a << shamt;
      ALU_SRL:          result_o = op.operand_a >> shamt;
      // Sign bit fills from the top
      ALU_SRA:          result_o = $unsigned($signed(op.operand_a) >>> shamt);
      // Set-less-than and branch compares land in bit 0
      default:          result_o = {{(`EX_XLEN-1){1'b0}}, cmp_result_o};
    endcase
  end

endmodule

//--- ex_mult.sv
`timescale 1ns/1ps
`include "ex_config.svh"

module ex_mult
  import ex_pkg::*;
(
  ex_op_if.mult                op,
  output logic [`EX_XLEN-1:0]  result_o
);

  localparam int HALF_W = `EX_XLEN / 2;

  // Selected halves for subword mode
  logic [HALF_W-1:0]    half_a;
  logic [HALF_W-1:0]    half_b;

  // Signedness of each half
  logic                 sign_a;
  logic                 sign_b;

  // Halves widened to a full word
  logic [`EX_XLEN-1:0]  ext_a;
  logic [`EX_XLEN-1:0]  ext_b;

  // Operands into the single shared multiplier
  logic [`EX_XLEN-1:0]  mul_a;
  logic [`EX_XLEN-1:0]  mul_b;

  logic [`EX_XLEN-1:0]  product;
  logic [`EX_XLEN-1:0]  acc;

  ////////////////////
  // Subword select
  ////////////////////

  // Bit 0 picks the half of a, bit 1 the half of b
  assign half_a = op.mult_sel_subword[0] ? op.operand_a[`EX_XLEN-1:HALF_W]
                                         : op.operand_a[HALF_W-1:0];
  assign half_b = op.mult_sel_subword[1] ? op.operand_b[`EX_XLEN-1:HALF_W]
                                         : op.operand_b[HALF_W-1:0];

  always_comb
  begin
    case (op.mult_signed_mode)
      MULT_SU:
      begin
        sign_a = 1'b1;
        sign_b = 1'b0;
      end
      MULT_US:
      begin
        sign_a = 1'b0;
        sign_b = 1'b1;
      end
      MULT_SS:
      begin
        sign_a = 1'b1;
        sign_b = 1'b1;
      end
      default:
      begin
        sign_a = 1'b0;
        sign_b = 1'b0;
      end
    endcase
  end

  // Sign or zero extension of each half
  assign ext_a = {{HALF_W{sign_a & half_a[HALF_W-1]}}, half_a};
  assign ext_b = {{HALF_W{sign_b & half_b[HALF_W-1]}}, half_b};

  ////////////////////
  // Multiply
  ////////////////////

  // Operands held at zero while the unit is idle to keep the array quiet
  assign mul_a = !op.mult_en   ? '0
               : op.vector_mode ? ext_a
               : op.operand_a;
  assign mul_b = !op.mult_en   ? '0
               : op.vector_mode ? ext_b
               : op.operand_b;

  // Low word only
  // Extended 16x16 products always fit in 32 bits, so the low word is exact
  assign product = mul_a * mul_b;

  // Accumulate operand c, wraps modulo 2^32
  assign acc      = op.mult_mac_en ? op.operand_c : '0;
  assign result_o = product + acc;

endmodule

//--- ex_ctrl.sv
`timescale 1ns/1ps
`include "ex_config.svh"

module ex_ctrl
(
  input  logic                    clk,
  input  logic                    rst_n,

  ex_op_if.ctrl                   op,

  // Block results
  input  logic [`EX_XLEN-1:0]     alu_result_i,
  input  logic                    alu_cmp_i,
  input  logic [`EX_XLEN-1:0]     mult_result_i,

  // CSR read path
  input  logic                    csr_access_i,
  input  logic [`EX_XLEN-1:0]     csr_rdata_i,

  // Write requests from decode
  input  logic                    regfile_alu_we_i,
  input  logic [`EX_RADDR_W-1:0]  regfile_alu_waddr_i,
  input  logic                    regfile_we_i,
  input  logic [`EX_RADDR_W-1:0]  regfile_waddr_i,

  // Downstream readiness
  input  logic                    lsu_ready_ex_i,
  input  logic                    wb_ready_i,

  // Forwarding path
  output logic [`EX_XLEN-1:0]     regfile_alu_wdata_fw_o,
  output logic                    regfile_alu_we_fw_o,
  output logic [`EX_RADDR_W-1:0]  regfile_alu_waddr_fw_o,

  // Branch outcome to fetch
  output logic                    branch_decision_o,
  output logic [`EX_XLEN-1:0]     jump_target_o,

  // EX/WB register
  output logic                    regfile_we_wb_o,
  output logic [`EX_RADDR_W-1:0]  regfile_waddr_wb_o,

  output logic                    ex_ready_o,
  output logic                    ex_valid_o
);

  // ALU write port passes straight through
  assign regfile_alu_we_fw_o    = regfile_alu_we_i;
  assign regfile_alu_waddr_fw_o = regfile_alu_waddr_i;

  // Result priority: CSR, then multiplier, then ALU
  always_comb
  begin
    if (csr_access_i)
      regfile_alu_wdata_fw_o = csr_rdata_i;
    else if (op.mult_en)
      regfile_alu_wdata_fw_o = mult_result_i;
    else
      regfile_alu_wdata_fw_o = alu_result_i;
  end

  // Target is computed in decode and rides on operand c
  assign branch_decision_o = alu_cmp_i;
  assign jump_target_o     = op.operand_c;

  ////////////////////
  // Stall control
  ////////////////////

  // Nothing is buffered here, so valid just mirrors ready
  assign ex_ready_o = lsu_ready_ex_i & wb_ready_i;
  assign ex_valid_o = ex_ready_o;

  ////////////////////
  // EX/WB register
  ////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      regfile_we_wb_o    <= 1'b0;
      regfile_waddr_wb_o <= '0;
    end
    else if (ex_valid_o)
    begin
      regfile_we_wb_o    <= regfile_we_i;
      regfile_waddr_wb_o <= regfile_waddr_i;
    end
    else if (wb_ready_i)
    begin
      // Writeback drained but the LSU stalls, so insert a bubble
      regfile_we_wb_o    <= 1'b0;
    end
  end

endmodule

//--- ex_stage.sv
`timescale 1ns/1ps
`include "ex_config.svh"

module ex_stage
  import ex_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n,

  // Operation from decode
  input  alu_op_e                 alu_operator_i,
  input  logic [`EX_XLEN-1:0]     alu_operand_a_i,
  input  logic [`EX_XLEN-1:0]     alu_operand_b_i,
  input  logic [`EX_XLEN-1:0]     alu_operand_c_i,

  input  logic                    vector_mode_i,

  // Multiplier controls
  input  logic                    mult_en_i,
  input  logic [1:0]              mult_sel_subword_i,
  input  mult_sign_e              mult_signed_mode_i,
  input  logic                    mult_mac_en_i,

  // ALU result write port
  input  logic [`EX_RADDR_W-1:0]  regfile_alu_waddr_i,
  input  logic                    regfile_alu_we_i,

  // Load write port, carried on to writeback
  input  logic                    regfile_we_i,
  input  logic [`EX_RADDR_W-1:0]  regfile_waddr_i,

  // CSR read
  input  logic                    csr_access_i,
  input  logic [`EX_XLEN-1:0]     csr_rdata_i,

  // EX/WB register outputs
  output logic [`EX_RADDR_W-1:0]  regfile_waddr_wb_o,
  output logic                    regfile_we_wb_o,

  // Forwarding to decode and register file
  output logic [`EX_RADDR_W-1:0]  regfile_alu_waddr_fw_o,
  output logic                    regfile_alu_we_fw_o,
  output logic [`EX_XLEN-1:0]     regfile_alu_wdata_fw_o,

  // Branch outcome to fetch
  output logic [`EX_XLEN-1:0]     jump_target_o,
  output logic                    branch_decision_o,

  // Handshake
  input  logic                    lsu_ready_ex_i,
  output logic                    ex_ready_o,
  output logic                    ex_valid_o,
  input  logic                    wb_ready_i
);

  logic [`EX_XLEN-1:0]  alu_result;
  logic                 alu_cmp_result;
  logic [`EX_XLEN-1:0]  mult_result;

  ////////////////////
  // Operation bundle
  ////////////////////

  ex_op_if op_bus ();

  assign op_bus.operator         = alu_operator_i;
  assign op_bus.operand_a        = alu_operand_a_i;
  assign op_bus.operand_b        = alu_operand_b_i;
  assign op_bus.operand_c        = alu_operand_c_i;
  assign op_bus.vector_mode      = vector_mode_i;
  assign op_bus.mult_en          = mult_en_i;
  assign op_bus.mult_sel_subword = mult_sel_subword_i;
  assign op_bus.mult_signed_mode = mult_signed_mode_i;
  assign op_bus.mult_mac_en      = mult_mac_en_i;

  ////////////////////
  // Datapath blocks
  ////////////////////

  ex_alu u_alu (
    .op           (op_bus),
    .result_o     (alu_result),
    .cmp_result_o (alu_cmp_result)
  );

  ex_mult u_mult (
    .op       (op_bus),
    .result_o (mult_result)
  );

  ////////////////////
  // Control
  ////////////////////

  ex_ctrl u_ctrl (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .op                     (op_bus),
    .alu_result_i           (alu_result),
    .alu_cmp_i              (alu_cmp_result),
    .mult_result_i          (mult_result),
    .csr_access_i           (csr_access_i),
    .csr_rdata_i            (csr_rdata_i),
    .regfile_alu_we_i       (regfile_alu_we_i),
    .regfile_alu_waddr_i    (regfile_alu_waddr_i),
    .regfile_we_i           (regfile_we_i),
    .regfile_waddr_i        (regfile_waddr_i),
    .lsu_ready_ex_i         (lsu_ready_ex_i),
    .wb_ready_i             (wb_ready_i),
    .regfile_alu_wdata_fw_o (regfile_alu_wdata_fw_o),
    .regfile_alu_we_fw_o    (regfile_alu_we_fw_o),
    .regfile_alu_waddr_fw_o (regfile_alu_waddr_fw_o),
    .branch_decision_o      (branch_decision_o),
    .jump_target_o          (jump_target_o),
    .regfile_we_wb_o        (regfile_we_wb_o),
    .regfile_waddr_wb_o     (regfile_waddr_wb_o),
    .ex_ready_o             (ex_ready_o),
    .ex_valid_o             (ex_valid_o)
  );

endmodule

//--- tb_ex_stage.sv
`timescale 1ns/1ps
`include "ex_config.svh"

module tb_ex_stage
  import ex_pkg::*;
();

  localparam int CLK_PERIOD   = 10;
  localparam int RESET_CYCLES = 5;

  // Vectors per test with one clock each
  localparam int N_WB   = 80;
  localparam int N_ALU  = 200;
  localparam int N_CMP  = 96;
  localparam int N_MULT = 116;
  localparam int N_PRIO = 40;
  localparam int N_HS   = 40;
  localparam int N_ALL  = N_WB + N_ALU + N_CMP + N_MULT + N_PRIO + N_HS;

  // Run budget plus 100 spare cycles
  localparam int TIMEOUT_NS = (N_ALL + RESET_CYCLES + 100) * CLK_PERIOD;

  // Directed compare pairs
  // Equal, sign differs both ways, unsigned-only difference, equal zero
  localparam logic [31:0] CMP_A [6] = '{32'h1234_5678, 32'h8000_0000, 32'h0000_0001,
                                         32'hffff_fff0, 32'h0000_0010, 32'h0000_0000};
  localparam logic [31:0] CMP_B [6] = '{32'h1234_5678, 32'h0000_0001, 32'h8000_0000,
                                         32'hffff_ffff, 32'h0000_0002, 32'h0000_0000};

  logic                    clk;
  logic                    rst_n;
  alu_op_e                 alu_operator_i;
  logic [`EX_XLEN-1:0]     alu_operand_a_i;
  logic [`EX_XLEN-1:0]     alu_operand_b_i;
  logic [`EX_XLEN-1:0]     alu_operand_c_i;
  logic                    vector_mode_i;
  logic                    mult_en_i;
  logic [1:0]              mult_sel_subword_i;
  mult_sign_e              mult_signed_mode_i;
  logic                    mult_mac_en_i;
  logic [`EX_RADDR_W-1:0]  regfile_alu_waddr_i;
  logic                    regfile_alu_we_i;
  logic                    regfile_we_i;
  logic [`EX_RADDR_W-1:0]  regfile_waddr_i;
  logic                    csr_access_i;
  logic [`EX_XLEN-1:0]     csr_rdata_i;
  logic [`EX_RADDR_W-1:0]  regfile_waddr_wb_o;
  logic                    regfile_we_wb_o;
  logic [`EX_RADDR_W-1:0]  regfile_alu_waddr_fw_o;
  logic                    regfile_alu_we_fw_o;
  logic [`EX_XLEN-1:0]     regfile_alu_wdata_fw_o;
  logic [`EX_XLEN-1:0]     jump_target_o;
  logic                    branch_decision_o;
  logic                    lsu_ready_ex_i;
  logic                    ex_ready_o;
  logic                    ex_valid_o;
  logic                    wb_ready_i;

  integer seed;
  int     errors;
  int     checks;
  int     tests_run;
  int     tests_failed;

  ex_stage DUT (.*);

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////
  // Reference model
  ////////////////////

  function automatic logic cmp_model(input alu_op_e opc, input logic [31:0] a,
                                     input logic [31:0] b);
    case (opc)
      ALU_EQ:  return a == b;
      ALU_NE:  return a != b;
      ALU_LT:  return $signed(a) < $signed(b);
      ALU_GE:  return $signed(a) >= $signed(b);
      ALU_LTU: return a < b;
      ALU_GEU: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic [31:0] alu_model(input alu_op_e opc, input logic [31:0] a,
                                            input logic [31:0] b);
    logic [4:0] sh;
    // Shift amount is the low five bits of b
    sh = b[4:0];
    case (opc)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a - b;
      ALU_AND:  return a & b;
      ALU_OR:   return a | b;
      ALU_XOR:  return a ^ b;
      ALU_SLL:  return a << sh;
      ALU_SRL:  return a >> sh;
      // Logical shift with the vacated top bits filled by the sign
      ALU_SRA:  return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
      ALU_SLT:  return {31'b0, cmp_model(ALU_LT, a, b)};
      ALU_SLTU: return {31'b0, cmp_model(ALU_LTU, a, b)};
      default:  return 32'h0;
    endcase
  endfunction

  function automatic logic [31:0] mult_model(input logic [31:0] a, input logic [31:0] b,
                                             input logic [31:0] c, input logic vec,
                                             input logic [1:0] sel, input mult_sign_e mode,
                                             input logic mac);
    logic [15:0] ha;
    logic [15:0] hb;
    longint      ea;
    longint      eb;
    logic [31:0] prod;
    ha = sel[0] ? a[31:16] : a[15:0];
    hb = sel[1] ? b[31:16] : b[15:0];
    // First letter of the mode is for a
    ea = (mode == MULT_SS || mode == MULT_SU) ? longint'($signed(ha)) : longint'(ha);
    eb = (mode == MULT_SS || mode == MULT_US) ? longint'($signed(hb)) : longint'(hb);
    if (vec)
      prod = 32'(ea * eb);
    else
      prod = a * b;
    return mac ? prod + c : prod;
  endfunction

  ////////////////////
  // Check helpers
  ////////////////////

  task automatic check_value(input string sig, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp)
    else
    begin
      $display("ERR %s expected %h got %h", sig, exp, act);
      errors++;
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    tests_run++;
    if (errors == errs_before)
      $display("%s: ok", name);
    else
    begin
      tests_failed++;
      $display("%s: failed with %0d errors", name, errors - errs_before);
    end
  endtask

  // Everything quiet and downstream not ready
  task automatic idle_inputs();
    alu_operator_i      = ALU_ADD;
    alu_operand_a_i     = '0;
    alu_operand_b_i     = '0;
    alu_operand_c_i     = '0;
    vector_mode_i       = 1'b0;
    mult_en_i           = 1'b0;
    mult_sel_subword_i  = 2'b00;
    mult_signed_mode_i  = MULT_UU;
    mult_mac_en_i       = 1'b0;
    regfile_alu_waddr_i = '0;
    regfile_alu_we_i    = 1'b0;
    regfile_we_i        = 1'b0;
    regfile_waddr_i     = '0;
    csr_access_i        = 1'b0;
    csr_rdata_i         = '0;
    lsu_ready_ex_i      = 1'b0;
    wb_ready_i          = 1'b0;
  endtask

  // Free-flowing pipe with the ALU result selected
  task automatic settle_controls();
    lsu_ready_ex_i = 1'b1;
    wb_ready_i     = 1'b1;
    regfile_we_i   = 1'b0;
    csr_access_i   = 1'b0;
    mult_en_i      = 1'b0;
    mult_mac_en_i  = 1'b0;
    vector_mode_i  = 1'b0;
  endtask

  ////////////////////
  // Tests
  ////////////////////

  task automatic wb_register_test();
    int                     errs_before;
    logic                   exp_we;
    logic [`EX_RADDR_W-1:0] exp_waddr;
    errs_before = errors;
    exp_we      = 1'b0;
    exp_waddr   = '0;
    for (int i = 0; i < N_WB; i++)
    begin
      @(negedge clk);
      lsu_ready_ex_i  = 1'($random(seed));
      wb_ready_i      = 1'($random(seed));
      regfile_we_i    = 1'($random(seed));
      regfile_waddr_i = 5'($random(seed));
      #1;
      // First pass sees the state left by reset
      check_value("regfile_we_wb_o", 32'(exp_we), 32'(regfile_we_wb_o));
      check_value("regfile_waddr_wb_o", 32'(exp_waddr), 32'(regfile_waddr_wb_o));
      // Next edge loads when valid, bubbles when only WB is ready, else holds
      if (lsu_ready_ex_i && wb_ready_i)
      begin
        exp_we    = regfile_we_i;
        exp_waddr = regfile_waddr_i;
      end
      else if (wb_ready_i)
        exp_we = 1'b0;
    end
    finish_test("EX/WB register", errs_before);
  endtask

  task automatic alu_arith_test();
    int errs_before;
    errs_before = errors;
    for (int i = 0; i < N_ALU; i++)
    begin
      @(negedge clk);
      settle_controls();
      // Non-compare opcodes only
      alu_operator_i  = alu_op_e'(4'($unsigned($random(seed)) % 10));
      alu_operand_a_i = $random(seed);
      alu_operand_b_i = $random(seed);
      #1;
      check_value("regfile_alu_wdata_fw_o",
                  alu_model(alu_operator_i, alu_operand_a_i, alu_operand_b_i),
                  regfile_alu_wdata_fw_o);
    end
    finish_test("ALU arithmetic", errs_before);
  endtask

  task automatic branch_compare_test();
    int      errs_before;
    alu_op_e opc;
    errs_before = errors;
    for (int k = int'(ALU_EQ); k <= int'(ALU_GEU); k++)
    begin
      opc = alu_op_e'(4'(k));
      for (int i = 0; i < N_CMP / 6; i++)
      begin
        @(negedge clk);
        settle_controls();
        alu_operator_i  = opc;
        alu_operand_a_i = (i < 6) ? CMP_A[i] : $random(seed);
        alu_operand_b_i = (i < 6) ? CMP_B[i] : $random(seed);
        alu_operand_c_i = $random(seed);
        #1;
        check_value("branch_decision_o",
                    32'(cmp_model(opc, alu_operand_a_i, alu_operand_b_i)),
                    32'(branch_decision_o));
        check_value("jump_target_o", alu_operand_c_i, jump_target_o);
      end
    end
    finish_test("Compares and branches", errs_before);
  endtask

  task automatic mult_vector(input logic vec, input logic [1:0] sel, input mult_sign_e mode,
                             input logic mac);
    @(negedge clk);
    settle_controls();
    mult_en_i          = 1'b1;
    vector_mode_i      = vec;
    mult_sel_subword_i = sel;
    mult_signed_mode_i = mode;
    mult_mac_en_i      = mac;
    alu_operand_a_i    = $random(seed);
    alu_operand_b_i    = $random(seed);
    alu_operand_c_i    = $random(seed);
    #1;
    check_value("regfile_alu_wdata_fw_o",
                mult_model(alu_operand_a_i, alu_operand_b_i, alu_operand_c_i,
                           vec, sel, mode, mac),
                regfile_alu_wdata_fw_o);
  endtask

  task automatic multiplier_test();
    int errs_before;
    errs_before = errors;
    // 20 full-word products
    for (int mac = 0; mac < 2; mac++)
      for (int i = 0; i < 10; i++)
        mult_vector(1'b0, 2'b00, MULT_UU, 1'(mac));
    // 96 vectors over every half select and signed mode
    for (int s = 0; s < 4; s++)
      for (int m = 0; m < 4; m++)
        for (int mac = 0; mac < 2; mac++)
          for (int i = 0; i < 3; i++)
            mult_vector(1'b1, 2'(s), mult_sign_e'(2'(m)), 1'(mac));
    finish_test("Multiplier", errs_before);
  endtask

  task automatic priority_test();
    int          errs_before;
    logic [31:0] exp;
    errs_before = errors;
    for (int i = 0; i < N_PRIO; i++)
    begin
      @(negedge clk);
      settle_controls();
      csr_access_i        = 1'($random(seed));
      mult_en_i           = 1'($random(seed));
      mult_mac_en_i       = 1'($random(seed));
      alu_operator_i      = alu_op_e'(4'($unsigned($random(seed)) % 10));
      alu_operand_a_i     = $random(seed);
      alu_operand_b_i     = $random(seed);
      alu_operand_c_i     = $random(seed);
      csr_rdata_i         = $random(seed);
      regfile_alu_we_i    = 1'($random(seed));
      regfile_alu_waddr_i = 5'($random(seed));
      #1;
      // CSR beats multiplier beats ALU
      if (csr_access_i)
        exp = csr_rdata_i;
      else if (mult_en_i)
        exp = mult_model(alu_operand_a_i, alu_operand_b_i, alu_operand_c_i, 1'b0,
                         mult_sel_subword_i, mult_signed_mode_i, mult_mac_en_i);
      else
        exp = alu_model(alu_operator_i, alu_operand_a_i, alu_operand_b_i);
      check_value("regfile_alu_wdata_fw_o", exp, regfile_alu_wdata_fw_o);
      check_value("regfile_alu_we_fw_o", 32'(regfile_alu_we_i), 32'(regfile_alu_we_fw_o));
      check_value("regfile_alu_waddr_fw_o", 32'(regfile_alu_waddr_i),
                  32'(regfile_alu_waddr_fw_o));
    end
    finish_test("Result priority", errs_before);
  endtask

  task automatic handshake_test();
    int errs_before;
    errs_before = errors;
    for (int i = 0; i < N_HS; i++)
    begin
      @(negedge clk);
      lsu_ready_ex_i = 1'($random(seed));
      wb_ready_i     = 1'($random(seed));
      regfile_we_i   = 1'($random(seed));
      #1;
      check_value("ex_ready_o", 32'(lsu_ready_ex_i & wb_ready_i), 32'(ex_ready_o));
      check_value("ex_valid_o", 32'(lsu_ready_ex_i & wb_ready_i), 32'(ex_valid_o));
    end
    finish_test("Handshake", errs_before);
  endtask

  ////////////////////
  // Clocked rules
  ////////////////////

  // Ready is the AND of both readies and valid mirrors it
  hs_rule: assert property (@(posedge clk)
    ex_ready_o == (lsu_ready_ex_i & wb_ready_i) && ex_valid_o == ex_ready_o)
  else
  begin
    $display("Handshake outputs disagree with the downstream readies");
    errors++;
  end

  wb_load: assert property (@(posedge clk) disable iff (!rst_n)
    $past(ex_valid_o) |-> regfile_we_wb_o == $past(regfile_we_i)
                          && regfile_waddr_wb_o == $past(regfile_waddr_i))
  else
  begin
    $display("EX/WB register did not load after a valid cycle");
    errors++;
  end

  // LSU stall with WB ready leaves a bubble
  wb_flush: assert property (@(posedge clk) disable iff (!rst_n)
    $past(wb_ready_i) && !$past(lsu_ready_ex_i) |-> !regfile_we_wb_o)
  else
  begin
    $display("EX/WB write enable not cleared after an LSU stall");
    errors++;
  end

  wb_hold: assert property (@(posedge clk) disable iff (!rst_n)
    !$past(wb_ready_i) && !$past(lsu_ready_ex_i)
      |-> regfile_we_wb_o == $past(regfile_we_wb_o)
          && regfile_waddr_wb_o == $past(regfile_waddr_wb_o))
  else
  begin
    $display("EX/WB register changed while both readies were low");
    errors++;
  end

  ////////////////////
  // Main sequence
  ////////////////////

  initial
  begin
    seed         = 98;
    errors       = 0;
    checks       = 0;
    tests_run    = 0;
    tests_failed = 0;
    rst_n        = 1'b0;
    idle_inputs();
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;

    wb_register_test();
    alu_arith_test();
    branch_compare_test();
    multiplier_test();
    priority_test();
    handshake_test();

    // Let the last clocked checks fire
    repeat (2) @(negedge clk);
    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

  // Watchdog
  initial
  begin
    #(TIMEOUT_NS);
    $display("Watchdog expired, the run went past %0d ns", TIMEOUT_NS);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

//--- tb.f
+incdir+.
ex_pkg.sv
ex_op_if.sv
ex_alu.sv
ex_mult.sv
ex_ctrl.sv
ex_stage.sv
tb_ex_stage.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, and decide by the pass line in the log
LOG=sim.log

verilator --binary --assert --top-module tb_ex_stage -f tb.f > "$LOG" 2>&1 &&
  ./obj_dir/Vtb_ex_stage >> "$LOG" 2>&1 ||
  echo "Build or simulation error" >> "$LOG"

cat "$LOG"
grep -qF "*** TEST PASSED ***" "$LOG" && echo "Simulation passed" && exit 0 ||
  { echo "Simulation failed"; exit 1; }
